// File: include/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// register file sizes seen by rename
`define ROB_ARCH_REGS 32
`define ROB_PHYS_REGS 64

// number of rob entries, must be a power of two
`define ROB_DEPTH 16

`endif

// File: verilog/rob_pkg.sv
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    // architectural destination register number
    typedef logic [$clog2(`ROB_ARCH_REGS)-1:0] arch_reg_t;

    // physical register number, new and old mapping
    typedef logic [$clog2(`ROB_PHYS_REGS)-1:0] phys_reg_t;

    // entry index, wraps at ROB_DEPTH
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy 0..ROB_DEPTH, one bit wider than an index
    typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t;

endpackage

`default_nettype wire

// File: verilog/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_alloc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              uop_update,
    input  logic              except,
    input  logic              retire_en,
    output logic              alloc_en,
    output rob_pkg::rob_idx_t tail_ptr,
    output logic              rob_full
);

    import rob_pkg::*;

    localparam rob_count_t DEPTH_CNT = rob_count_t'(`ROB_DEPTH);

    rob_count_t count;

    // full is a plain decode of the count register
    assign rob_full = (count == DEPTH_CNT);

    // updates while full are dropped and flush wins over everything
    assign alloc_en = uop_update && !rob_full && !except;

    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            tail_ptr <= '0;
        end else if (alloc_en) begin
            tail_ptr <= tail_ptr + rob_idx_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            count <= '0;
        end else begin
            case ({alloc_en, retire_en})
                2'b10: begin
                    count <= count + rob_count_t'(1);
                end
                2'b01: begin
                    count <= count - rob_count_t'(1);
                end
                default: begin
                    // occupancy holds on both or neither
                    count <= count;
                end
            endcase
        end
    end

    // occupancy stays within the entry store over the whole run
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= DEPTH_CNT
    ) else $error("rob occupancy %0d above depth", count);

    // rename must hold off while the buffer reports full
    a_no_update_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        rob_full |-> !uop_update
    ) else $error("uop_update while rob_full");

endmodule

`default_nettype wire

// File: verilog/rob_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_store (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_en,
    input  logic               uop_finish,
    input  logic               except,
    input  logic               retire_en,
    input  rob_pkg::rob_idx_t  tail_ptr,
    input  rob_pkg::rob_idx_t  head_ptr,
    input  rob_pkg::rob_idx_t  uop_finish_rob_entry,
    input  rob_pkg::arch_reg_t uop_dest_arch_in,
    input  rob_pkg::phys_reg_t uop_dest_phys_in,
    input  rob_pkg::phys_reg_t uop_dest_oldphys_in,
    output logic               head_ready,
    output rob_pkg::arch_reg_t head_arch,
    output rob_pkg::phys_reg_t head_phys,
    output rob_pkg::phys_reg_t head_oldphys
);

    import rob_pkg::*;

    arch_reg_t arch_mem    [`ROB_DEPTH];
    phys_reg_t phys_mem    [`ROB_DEPTH];
    phys_reg_t oldphys_mem [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0] ready;
    logic [`ROB_DEPTH-1:0] valid;

    // register fields written at the tail
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            arch_mem[tail_ptr]    <= uop_dest_arch_in;
            phys_mem[tail_ptr]    <= uop_dest_phys_in;
            oldphys_mem[tail_ptr] <= uop_dest_oldphys_in;
        end
    end

    // ready bits, set by completion and cleared as the head retires
    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            ready <= '0;
        end else begin
            if (retire_en) begin
                ready[head_ptr] <= 1'b0;
            end
            if (uop_finish) begin
                ready[uop_finish_rob_entry] <= 1'b1;
            end
        end
    end

    // occupancy map for protocol checking
    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            valid <= '0;
        end else begin
            if (retire_en) begin
                valid[head_ptr] <= 1'b0;
            end
            if (alloc_en) begin
                valid[tail_ptr] <= 1'b1;
            end
        end
    end

    assign head_ready   = ready[head_ptr];
    assign head_arch    = arch_mem[head_ptr];
    assign head_phys    = phys_mem[head_ptr];
    assign head_oldphys = oldphys_mem[head_ptr];

    // completion network may only finish a live, unfinished entry
    a_finish_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (uop_finish && !except) |->
            (valid[uop_finish_rob_entry] && !ready[uop_finish_rob_entry])
    ) else $error("finish of rob entry %0d not allocated or already done",
                  uop_finish_rob_entry);

    // a retiring head must hold an allocated micro-op
    a_retire_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_en |-> valid[head_ptr]
    ) else $error("retire of empty rob entry %0d", head_ptr);

endmodule

`default_nettype wire

// File: verilog/rob_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rob_retire (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               except,
    input  logic               head_ready,
    input  rob_pkg::arch_reg_t head_arch,
    input  rob_pkg::phys_reg_t head_phys,
    input  rob_pkg::phys_reg_t head_oldphys,
    output logic               retire_en,
    output rob_pkg::rob_idx_t  head_ptr,
    output logic               retire_uop,
    output rob_pkg::arch_reg_t uop_dest_arch_out,
    output rob_pkg::phys_reg_t uop_dest_phys_out,
    output rob_pkg::phys_reg_t uop_dest_oldphys_out
);

    import rob_pkg::*;

    rob_idx_t head_next;

    // in-order retirement, one per cycle, never during a flush
    assign retire_en = head_ready && !except;

    assign head_next = head_ptr + rob_idx_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            head_ptr <= '0;
        end else if (retire_en) begin
            head_ptr <= head_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || except) begin
            retire_uop <= 1'b0;
        end else begin
            retire_uop <= retire_en;
        end
    end

    // commit and free-list payload, only meaningful with retire_uop
    always_ff @(posedge clk) begin
        if (retire_en) begin
            uop_dest_arch_out    <= head_arch;
            uop_dest_phys_out    <= head_phys;
            uop_dest_oldphys_out <= head_oldphys;
        end
    end

    // every strobe comes from a retire decision one cycle earlier,
    // and none survives a flush
    a_retire_origin: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_uop |-> ($past(retire_en) && !$past(except))
    ) else $error("retire_uop without a retire decision");

endmodule

`default_nettype wire

// File: verilog/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               uop_update,
    input  rob_pkg::arch_reg_t uop_dest_arch_in,
    input  rob_pkg::phys_reg_t uop_dest_phys_in,
    input  rob_pkg::phys_reg_t uop_dest_oldphys_in,

    input  logic               uop_finish,
    input  rob_pkg::rob_idx_t  uop_finish_rob_entry,

    input  logic               except,

    output rob_pkg::rob_idx_t  next_rob_entry,
    output logic               rob_full,

    output logic               retire_uop,
    output rob_pkg::arch_reg_t uop_dest_arch_out,
    output rob_pkg::phys_reg_t uop_dest_phys_out,
    output rob_pkg::phys_reg_t uop_dest_oldphys_out
);

    import rob_pkg::*;

    logic      alloc_en;
    logic      retire_en;
    logic      head_ready;
    rob_idx_t  tail_ptr;
    rob_idx_t  head_ptr;
    arch_reg_t head_arch;
    phys_reg_t head_phys;
    phys_reg_t head_oldphys;

    // rename sees the slot it will get next
    assign next_rob_entry = tail_ptr;

    rob_alloc u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_update (uop_update),
        .except     (except),
        .retire_en  (retire_en),
        .alloc_en   (alloc_en),
        .tail_ptr   (tail_ptr),
        .rob_full   (rob_full)
    );

    rob_store u_store (
        .clk                  (clk),
        .rst_n                (rst_n),
        .alloc_en             (alloc_en),
        .uop_finish           (uop_finish),
        .except               (except),
        .retire_en            (retire_en),
        .tail_ptr             (tail_ptr),
        .head_ptr             (head_ptr),
        .uop_finish_rob_entry (uop_finish_rob_entry),
        .uop_dest_arch_in     (uop_dest_arch_in),
        .uop_dest_phys_in     (uop_dest_phys_in),
        .uop_dest_oldphys_in  (uop_dest_oldphys_in),
        .head_ready           (head_ready),
        .head_arch            (head_arch),
        .head_phys            (head_phys),
        .head_oldphys         (head_oldphys)
    );

    rob_retire u_retire (
        .clk                  (clk),
        .rst_n                (rst_n),
        .except               (except),
        .head_ready           (head_ready),
        .head_arch            (head_arch),
        .head_phys            (head_phys),
        .head_oldphys         (head_oldphys),
        .retire_en            (retire_en),
        .head_ptr             (head_ptr),
        .retire_uop           (retire_uop),
        .uop_dest_arch_out    (uop_dest_arch_out),
        .uop_dest_phys_out    (uop_dest_phys_out),
        .uop_dest_oldphys_out (uop_dest_oldphys_out)
    );

endmodule

`default_nettype wire

// File: tests/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_tb;

    import rob_pkg::*;

    localparam int MAX_ROWS  = 80;
    localparam int NUM_TESTS = 6;

    logic      clk;
    logic      rst_n;
    logic      uop_update;
    arch_reg_t uop_dest_arch_in;
    phys_reg_t uop_dest_phys_in;
    phys_reg_t uop_dest_oldphys_in;
    logic      uop_finish;
    rob_idx_t  uop_finish_rob_entry;
    logic      except;
    rob_idx_t  next_rob_entry;
    logic      rob_full;
    logic      retire_uop;
    arch_reg_t uop_dest_arch_out;
    phys_reg_t uop_dest_phys_out;
    phys_reg_t uop_dest_oldphys_out;

    // stimulus columns
    logic      t_upd     [MAX_ROWS];
    arch_reg_t t_arch    [MAX_ROWS];
    phys_reg_t t_phys    [MAX_ROWS];
    phys_reg_t t_oldphys [MAX_ROWS];
    logic      t_fin     [MAX_ROWS];
    rob_idx_t  t_fin_idx [MAX_ROWS];
    logic      t_exc     [MAX_ROWS];
    // expected columns valid right after the edge that samples the row
    rob_idx_t  t_next    [MAX_ROWS];
    logic      t_full    [MAX_ROWS];
    logic      t_retire  [MAX_ROWS];
    logic      t_acc     [MAX_ROWS];
    rob_idx_t  t_idx     [MAX_ROWS];
    int        t_test    [MAX_ROWS];
    string     test_name [NUM_TESTS];
    int        num_rows;
    logic      table_built;

    // occupancy bookkeeping while the table is built
    rob_idx_t              m_tail;
    rob_idx_t              m_head;
    int                    m_count;
    logic [`ROB_DEPTH-1:0] m_ready;

    integer seed;
    int     errors;
    int     passes;

    // scoreboard of allocated micro-ops in age order
    rob_idx_t  q_idx     [$];
    arch_reg_t q_arch    [$];
    phys_reg_t q_phys    [$];
    phys_reg_t q_oldphys [$];

    rob_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .uop_update           (uop_update),
        .uop_dest_arch_in     (uop_dest_arch_in),
        .uop_dest_phys_in     (uop_dest_phys_in),
        .uop_dest_oldphys_in  (uop_dest_oldphys_in),
        .uop_finish           (uop_finish),
        .uop_finish_rob_entry (uop_finish_rob_entry),
        .except               (except),
        .next_rob_entry       (next_rob_entry),
        .rob_full             (rob_full),
        .retire_uop           (retire_uop),
        .uop_dest_arch_out    (uop_dest_arch_out),
        .uop_dest_phys_out    (uop_dest_phys_out),
        .uop_dest_oldphys_out (uop_dest_oldphys_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t ns: %s expected %0h, actual %0h",
                     $time, name, exp, act);
            errors++;
        end else begin
            passes++;
        end
    endtask

    // one cycle of stimulus and its expected outputs
    task automatic add_row(input int test, input logic upd, input logic fin,
                           input int fin_idx, input logic exc);
        int   r;
        logic alloc;
        logic retire;
        r      = num_rows;
        alloc  = upd && (m_count < `ROB_DEPTH) && !exc;
        retire = m_ready[m_head] && !exc;
        t_test[r]    = test;
        t_upd[r]     = upd;
        t_arch[r]    = arch_reg_t'($random(seed));
        t_phys[r]    = phys_reg_t'($random(seed));
        t_oldphys[r] = phys_reg_t'($random(seed));
        t_fin[r]     = fin;
        t_fin_idx[r] = rob_idx_t'(fin_idx);
        t_exc[r]     = exc;
        t_acc[r]     = alloc;
        t_idx[r]     = m_tail;
        if (exc) begin
            m_tail  = '0;
            m_head  = '0;
            m_count = 0;
            m_ready = '0;
        end else begin
            if (retire) begin
                m_ready[m_head] = 1'b0;
                m_head = m_head + rob_idx_t'(1);
            end
            if (fin) begin
                m_ready[fin_idx] = 1'b1;
            end
            if (alloc) begin
                m_tail = m_tail + rob_idx_t'(1);
            end
            m_count = m_count + int'(alloc) - int'(retire);
        end
        t_next[r]   = m_tail;
        t_full[r]   = (m_count == `ROB_DEPTH);
        t_retire[r] = retire;
        num_rows++;
    endtask

    task automatic idle_rows(input int test, input int n);
        repeat (n) add_row(test, 1'b0, 1'b0, 0, 1'b0);
    endtask

    task automatic update_rows(input int test, input int n);
        repeat (n) add_row(test, 1'b1, 1'b0, 0, 1'b0);
    endtask

    task automatic finish_entry(input int test, input int idx);
        add_row(test, 1'b0, 1'b1, idx, 1'b0);
    endtask

    task automatic build_table();
        seed    = 32'h92450212;
        m_tail  = '0;
        m_head  = '0;
        m_count = 0;
        m_ready = '0;
        idle_rows(0, 1);
        // fill and free the head so full drops with the first retirement
        update_rows(1, `ROB_DEPTH);
        idle_rows(1, 1);
        finish_entry(1, 0);
        idle_rows(1, 2);
        // out of order completion behind head 1
        finish_entry(2, 5);
        finish_entry(2, 3);
        finish_entry(2, 4);
        finish_entry(2, 2);
        finish_entry(2, 1);
        idle_rows(2, 6);
        // head 6 alone
        finish_entry(3, 6);
        idle_rows(3, 3);
        // flush with 8 and 9 done but head 7 still pending
        finish_entry(4, 8);
        finish_entry(4, 9);
        add_row(4, 1'b0, 1'b0, 0, 1'b1);
        idle_rows(4, 3);
        // allocation overlapping retirement one entry short of full
        update_rows(5, `ROB_DEPTH - 2);
        add_row(5, 1'b1, 1'b1, 0, 1'b0);
        add_row(5, 1'b1, 1'b1, 1, 1'b0);
        add_row(5, 1'b1, 1'b1, 2, 1'b0);
        finish_entry(5, 4);
        finish_entry(5, 3);
        idle_rows(5, 3);
    endtask

    task automatic apply_row(input int r);
        uop_update           = t_upd[r];
        uop_dest_arch_in     = t_arch[r];
        uop_dest_phys_in     = t_phys[r];
        uop_dest_oldphys_in  = t_oldphys[r];
        uop_finish           = t_fin[r];
        uop_finish_rob_entry = t_fin_idx[r];
        except               = t_exc[r];
        if (t_acc[r]) begin
            q_idx.push_back(t_idx[r]);
            q_arch.push_back(t_arch[r]);
            q_phys.push_back(t_phys[r]);
            q_oldphys.push_back(t_oldphys[r]);
        end
    endtask

    task automatic check_row(input int r);
        check($sformatf("next_rob_entry (row %0d)", r), t_next[r], next_rob_entry);
        check($sformatf("rob_full (row %0d)", r), t_full[r], rob_full);
        check($sformatf("retire_uop (row %0d)", r), t_retire[r], retire_uop);
    endtask

    task automatic report_test(input int t, input int errs);
        $display("test %0d (%s) finished with %0d errors", t, test_name[t], errs);
    endtask

    // retirement payload against the oldest allocated micro-op
    always @(negedge clk) begin
        rob_idx_t idx;
        if (rst_n === 1'b1 && retire_uop === 1'b1) begin
            if (q_idx.size() == 0) begin
                $display("ERROR at %0t ns: retirement seen while no micro-op was in flight",
                         $time);
                errors++;
            end else begin
                idx = q_idx.pop_front();
                check($sformatf("uop_dest_arch_out (rob %0d)", idx),
                      q_arch.pop_front(), uop_dest_arch_out);
                check($sformatf("uop_dest_phys_out (rob %0d)", idx),
                      q_phys.pop_front(), uop_dest_phys_out);
                check($sformatf("uop_dest_oldphys_out (rob %0d)", idx),
                      q_oldphys.pop_front(), uop_dest_oldphys_out);
            end
        end
    end

    initial begin
        wait (table_built === 1'b1);
        #((num_rows + 50) * 40);
        $display("ERROR: watchdog expired before the test table finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int cur_test;
        int err_base;
        test_name[0] = "reset state";
        test_name[1] = "fill and full";
        test_name[2] = "out of order finish";
        test_name[3] = "head finish latency";
        test_name[4] = "flush in flight";
        test_name[5] = "alloc with retire";
        rst_n                = 1'b0;
        uop_update           = 1'b0;
        uop_dest_arch_in     = '0;
        uop_dest_phys_in     = '0;
        uop_dest_oldphys_in  = '0;
        uop_finish           = 1'b0;
        uop_finish_rob_entry = '0;
        except               = 1'b0;
        errors               = 0;
        passes               = 0;
        num_rows             = 0;
        table_built          = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check("next_rob_entry after reset", 0, next_rob_entry);
        check("rob_full after reset", 0, rob_full);
        check("retire_uop after reset", 0, retire_uop);
        cur_test = 0;
        err_base = 0;
        for (int i = 0; i <= num_rows; i++) begin
            @(posedge clk);
            #2;
            if (i > 0) begin
                check_row(i - 1);
                // flush took effect at the edge just passed
                if (t_exc[i - 1]) begin
                    q_idx.delete();
                    q_arch.delete();
                    q_phys.delete();
                    q_oldphys.delete();
                end
            end
            if (i < num_rows) begin
                if (t_test[i] != cur_test) begin
                    report_test(cur_test, errors - err_base);
                    cur_test = t_test[i];
                    err_base = errors;
                end
                apply_row(i);
            end
        end
        @(posedge clk);
        report_test(cur_test, errors - err_base);
        $display("checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
verilog/rob_pkg.sv
verilog/rob_alloc.sv
verilog/rob_store.sv
verilog/rob_retire.sv
verilog/rob_top.sv
tests/rob_tb.sv
